/* hw/cache_ri_pkg.sv */
`default_nettype none

package cache_ri_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Cache geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int num_ways         = 4;
  localparam int way_bits         = $clog2(num_ways);
  localparam int line_words       = 16;
  localparam int word_bits        = $clog2(line_words);
  localparam int line_offset_bits = 6;
  localparam int burst_count_bits = 5;

  typedef logic [way_bits-1:0] way_t;

  typedef enum logic [1:0] {
    rw_nop   = 2'd0,
    rw_io    = 2'd1,
    rw_evict = 2'd2
  } rw_op_e;

  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_io_read   = 3'd1,
    st_io_write  = 3'd2,
    st_tag_read  = 3'd3,
    st_writeback = 3'd4,
    st_done      = 3'd5
  } ctrl_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request, lookup result and bus command.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [31:0] address;
    logic [3:0]  byte_enable;
    logic        read;
    logic        write;
    logic [31:0] write_data;
  } rw_req_t;

  typedef struct packed {
    logic hit;
    way_t hit_way;
    logic has_free;
    way_t free_way;
  } lookup_t;

  typedef struct packed {
    logic [31:0]                 address;
    logic [3:0]                  byte_enable;
    logic                        read;
    logic                        write;
    logic [31:0]                 write_data;
    logic                        begin_burst;
    logic [burst_count_bits-1:0] burst_count;
  } av_cmd_t;

endpackage

`default_nettype wire

/* hw/cache_ri_cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri_cmd_fifo #(
  parameter int fifo_depth = 2
) (
  input  wire                         clk,
  input  wire                         rest,
  input  wire                         push,
  input  wire cache_ri_pkg::av_cmd_t  push_cmd,
  input  wire                         pop,
  output cache_ri_pkg::av_cmd_t       head,
  output logic                        empty,
  output logic                        full
);

  import cache_ri_pkg::*;

  localparam int ptr_bits   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int count_bits = $clog2(fifo_depth + 1);

  av_cmd_t               mem [fifo_depth];
  logic [ptr_bits-1:0]   rd_ptr;
  logic [ptr_bits-1:0]   wr_ptr;
  logic [count_bits-1:0] count;
  logic                  do_write;
  logic                  do_read;

  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    if (ptr == ptr_bits'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == count_bits'(fifo_depth));

  // Push and pop on an empty FIFO pass the command straight through.
  assign do_write = push && !(empty && pop);
  assign do_read  = pop && !empty;

  always_comb begin
    if (!empty) begin
      head = mem[rd_ptr];
    end else if (push) begin
      head = push_cmd;
    end else begin
      head = '0;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  assert property (@(posedge clk) disable iff (!rest) push |-> !full)
    else $error("Command pushed into a full FIFO.");

  assert property (@(posedge clk) disable iff (!rest) (pop && empty) |-> push)
    else $error("Command popped from an empty FIFO.");

endmodule

`default_nettype wire

/* hw/cache_ri_way_select.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri_way_select #(
  parameter int set_bits = 5
) (
  input  wire                         clk,
  input  wire                         rest,
  input  wire                         start,
  input  wire cache_ri_pkg::lookup_t  lookup,
  input  wire [set_bits-1:0]          set_index,
  output cache_ri_pkg::way_t          way
);

  import cache_ri_pkg::*;

  localparam int num_sets = 2 ** set_bits;

  // One round-robin counter per set.
  way_t [num_sets-1:0] rr_cnt;
  way_t                victim;
  logic                replace;

  assign replace = !lookup.hit && !lookup.has_free;

  always_comb begin
    if (lookup.hit) begin
      victim = lookup.hit_way;
    end else if (lookup.has_free) begin
      victim = lookup.free_way;
    end else begin
      victim = rr_cnt[set_index];
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      way    <= '0;
      rr_cnt <= '0;
    end else if (start) begin
      way <= victim;
      // Counter wraps with the width of a way number.
      if (replace) begin
        rr_cnt[set_index] <= way_t'(rr_cnt[set_index] + 1'b1);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/cache_ri_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri_writeback #(
  parameter int set_bits = 5
) (
  input  wire                                                 clk,
  input  wire                                                 rest,
  input  wire                                                 start,
  input  wire [31-cache_ri_pkg::line_offset_bits-set_bits:0]  victim_tag,
  input  wire [set_bits-1:0]                                  set_index,
  input  wire [31:0]                                          data_read_data,
  input  wire                                                 fifo_full,
  input  wire                                                 beat_accepted,
  output logic [set_bits+cache_ri_pkg::word_bits-1:0]         data_read_address,
  output logic                                                push,
  output cache_ri_pkg::av_cmd_t                               push_cmd,
  output logic                                                finish
);

  import cache_ri_pkg::*;

  localparam logic [word_bits-1:0] last_word = word_bits'(line_words - 1);

  logic                 active;
  logic                 rd_on;
  logic [word_bits-1:0] rd_cnt;
  logic [word_bits-1:0] push_cnt;
  logic [word_bits-1:0] acc_cnt;
  logic                 rd_en;
  logic                 ram_valid;
  logic                 hold_valid;
  logic                 load_hold;
  logic [31:0]          hold_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data RAM reads and the hold slot.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rd_en             = rd_on && !fifo_full;
  assign data_read_address = {set_index, rd_cnt};

  // A returned word waits here when the FIFO cannot take it.
  assign load_hold = ram_valid && (fifo_full || hold_valid);
  assign push      = (hold_valid || ram_valid) && !fifo_full;

  always_comb begin
    push_cmd             = '0;
    push_cmd.address     = {victim_tag, set_index, push_cnt,
                            {(line_offset_bits - word_bits){1'b0}}};
    push_cmd.byte_enable = 4'hf;
    push_cmd.write       = 1'b1;
    push_cmd.write_data  = hold_valid ? hold_word : data_read_data;
    push_cmd.begin_burst = (push_cnt == '0);
    push_cmd.burst_count = burst_count_bits'(line_words);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat counters.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      active     <= 1'b0;
      rd_on      <= 1'b0;
      rd_cnt     <= '0;
      push_cnt   <= '0;
      acc_cnt    <= '0;
      ram_valid  <= 1'b0;
      hold_valid <= 1'b0;
      finish     <= 1'b0;
    end else begin
      ram_valid  <= rd_en;
      hold_valid <= load_hold || (hold_valid && fifo_full);
      finish     <= active && beat_accepted && (acc_cnt == last_word);
      if (start) begin
        active   <= 1'b1;
        rd_on    <= 1'b1;
        rd_cnt   <= '0;
        push_cnt <= '0;
        acc_cnt  <= '0;
      end else begin
        if (rd_en) begin
          rd_cnt <= rd_cnt + 1'b1;
          if (rd_cnt == last_word) begin
            rd_on <= 1'b0;
          end
        end
        if (push) begin
          push_cnt <= push_cnt + 1'b1;
        end
        if (active && beat_accepted) begin
          acc_cnt <= acc_cnt + 1'b1;
          if (acc_cnt == last_word) begin
            active <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_hold) begin
      hold_word <= data_read_data;
    end
  end

  assert property (@(posedge clk) disable iff (!rest) start |-> !active)
    else $error("Write-back started during an active burst.");

endmodule

`default_nettype wire

/* hw/cache_ri_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri_ctrl #(
  parameter int set_bits = 5
) (
  input  wire                                                  clk,
  input  wire                                                  rest,
  input  wire cache_ri_pkg::rw_op_e                            rw_cmd,
  input  wire cache_ri_pkg::rw_req_t                           rw_req,
  input  wire [31:0]                                           tag_read_data,
  input  wire                                                  av_accepted,
  input  wire                                                  av_read_data_valid,
  input  wire                                                  wb_finish,
  output logic                                                 rw_busy,
  output logic                                                 rw_done,
  output logic [set_bits-1:0]                                  set_index,
  output logic [31-cache_ri_pkg::line_offset_bits-set_bits:0]  victim_tag,
  output logic                                                 io_push,
  output cache_ri_pkg::av_cmd_t                                io_cmd,
  output logic                                                 way_start,
  output logic                                                 wb_start
);

  import cache_ri_pkg::*;

  localparam int tag_bits = 32 - line_offset_bits - set_bits;

  ctrl_state_e state;
  rw_req_t     req_q;
  logic        tag_phase;
  logic        accept;
  logic        dirty;

  assign accept    = (state == st_idle) && (rw_cmd inside {rw_io, rw_evict});
  assign way_start = (state == st_idle) && (rw_cmd == rw_evict);
  assign rw_busy   = (state != st_idle);
  assign dirty     = tag_read_data[tag_bits];

  // Way selection needs the set while the strobe is still up.
  assign set_index = (state == st_idle) ? rw_req.address[line_offset_bits +: set_bits]
                                        : req_q.address[line_offset_bits +: set_bits];

  always_comb begin
    io_cmd             = '0;
    io_cmd.address     = req_q.address;
    io_cmd.byte_enable = req_q.byte_enable;
    io_cmd.read        = req_q.read;
    io_cmd.write       = req_q.write;
    io_cmd.write_data  = req_q.write_data;
    io_cmd.burst_count = burst_count_bits'(1);
  end

  always_comb begin
    case (state)
      st_io_read:   rw_done = av_read_data_valid;
      st_io_write:  rw_done = av_accepted;
      st_writeback: rw_done = wb_finish;
      st_done:      rw_done = 1'b1;
      default:      rw_done = 1'b0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state     <= st_idle;
      tag_phase <= 1'b0;
      io_push   <= 1'b0;
      wb_start  <= 1'b0;
    end else begin
      io_push  <= 1'b0;
      wb_start <= 1'b0;
      case (state)
        st_idle: begin
          tag_phase <= 1'b0;
          if (rw_cmd == rw_io) begin
            state   <= rw_req.read ? st_io_read : st_io_write;
            io_push <= 1'b1;
          end else if (rw_cmd == rw_evict) begin
            state <= st_tag_read;
          end
        end
        st_io_read: begin
          if (av_read_data_valid) begin
            state <= st_idle;
          end
        end
        st_io_write: begin
          if (av_accepted) begin
            state <= st_idle;
          end
        end
        st_tag_read: begin
          // Tag word arrives one cycle after the set is presented.
          tag_phase <= 1'b1;
          if (tag_phase) begin
            if (dirty) begin
              state    <= st_writeback;
              wb_start <= 1'b1;
            end else begin
              state <= st_done;
            end
          end
        end
        st_writeback: begin
          if (wb_finish) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= rw_req;
    end
    if ((state == st_tag_read) && tag_phase) begin
      victim_tag <= tag_read_data[tag_bits-1:0];
    end
  end

  assert property (@(posedge clk) disable iff (!rest) rw_busy |-> (rw_cmd == rw_nop))
    else $error("Request strobe while busy.");

endmodule

`default_nettype wire

/* hw/cache_ri.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri #(
  parameter int set_bits   = 5,
  parameter int fifo_depth = 2
) (
  input  wire                                          clk,
  input  wire                                          rest,
  input  wire cache_ri_pkg::rw_op_e                    rw_cmd,
  input  wire cache_ri_pkg::rw_req_t                   rw_req,
  input  wire cache_ri_pkg::lookup_t                   rw_lookup,
  input  wire [31:0]                                   tag_read_data,
  input  wire [31:0]                                   data_read_data,
  input  wire                                          av_wait_request,
  input  wire [31:0]                                   av_read_data,
  input  wire                                          av_read_data_valid,
  output logic                                         rw_busy,
  output logic                                         rw_done,
  output logic [31:0]                                  rw_rsp_data,
  output cache_ri_pkg::way_t                           tag_channel,
  output logic [set_bits-1:0]                          tag_read_address,
  output cache_ri_pkg::way_t                           data_channel,
  output logic [set_bits+cache_ri_pkg::word_bits-1:0]  data_read_address,
  output cache_ri_pkg::av_cmd_t                        av_cmd
);

  import cache_ri_pkg::*;

  localparam int tag_bits = 32 - line_offset_bits - set_bits;

  logic [set_bits-1:0] set_index;
  logic [tag_bits-1:0] victim_tag;
  way_t                way;
  logic                way_start;
  logic                wb_start;
  logic                wb_finish;
  logic                io_push;
  logic                wb_push;
  logic                fifo_push;
  av_cmd_t             io_cmd;
  av_cmd_t             wb_cmd;
  av_cmd_t             fifo_cmd;
  logic                fifo_empty;
  logic                fifo_full;
  logic                av_accepted;

  assign av_accepted      = (av_cmd.read || av_cmd.write) && !av_wait_request;
  assign fifo_push        = io_push || wb_push;
  assign fifo_cmd         = wb_push ? wb_cmd : io_cmd;
  assign rw_rsp_data      = av_read_data;
  assign tag_channel      = way;
  assign data_channel     = way;
  assign tag_read_address = set_index;

  cache_ri_ctrl #(
    .set_bits (set_bits)
  ) i_ctrl (
    .clk                (clk),
    .rest               (rest),
    .rw_cmd             (rw_cmd),
    .rw_req             (rw_req),
    .tag_read_data      (tag_read_data),
    .av_accepted        (av_accepted),
    .av_read_data_valid (av_read_data_valid),
    .wb_finish          (wb_finish),
    .rw_busy            (rw_busy),
    .rw_done            (rw_done),
    .set_index          (set_index),
    .victim_tag         (victim_tag),
    .io_push            (io_push),
    .io_cmd             (io_cmd),
    .way_start          (way_start),
    .wb_start           (wb_start)
  );

  cache_ri_way_select #(
    .set_bits (set_bits)
  ) i_way_select (
    .clk       (clk),
    .rest      (rest),
    .start     (way_start),
    .lookup    (rw_lookup),
    .set_index (set_index),
    .way       (way)
  );

  cache_ri_writeback #(
    .set_bits (set_bits)
  ) i_writeback (
    .clk               (clk),
    .rest              (rest),
    .start             (wb_start),
    .victim_tag        (victim_tag),
    .set_index         (set_index),
    .data_read_data    (data_read_data),
    .fifo_full         (fifo_full),
    .beat_accepted     (av_accepted),
    .data_read_address (data_read_address),
    .push              (wb_push),
    .push_cmd          (wb_cmd),
    .finish            (wb_finish)
  );

  cache_ri_cmd_fifo #(
    .fifo_depth (fifo_depth)
  ) i_cmd_fifo (
    .clk      (clk),
    .rest     (rest),
    .push     (fifo_push),
    .push_cmd (fifo_cmd),
    .pop      (av_accepted),
    .head     (av_cmd),
    .empty    (fifo_empty),
    .full     (fifo_full)
  );

  assert property (@(posedge clk) disable iff (!rest) !(io_push && wb_push))
    else $error("IO and write-back pushed in the same cycle.");

  // Every request drains the bus queue by the time it completes.
  assert property (@(posedge clk) disable iff (!rest) rw_done |=> fifo_empty)
    else $error("Commands left queued after completion.");

endmodule

`default_nettype wire

/* tests/cache_ri_tb_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri_tb_mem #(
  parameter int set_bits = 5
) (
  input  wire                                         clk,
  input  wire cache_ri_pkg::way_t                     tag_channel,
  input  wire [set_bits-1:0]                          tag_read_address,
  input  wire cache_ri_pkg::way_t                     data_channel,
  input  wire [set_bits+cache_ri_pkg::word_bits-1:0]  data_read_address,
  input  wire cache_ri_pkg::av_cmd_t                  av_cmd,
  input  wire                                         av_wait_request,
  output logic [31:0]                                 tag_read_data,
  output logic [31:0]                                 data_read_data,
  output logic [31:0]                                 av_read_data,
  output logic                                        av_read_data_valid
);

  import cache_ri_pkg::*;

  localparam int tag_bits = 32 - line_offset_bits - set_bits;

  logic        rd_valid_q;
  logic [31:0] rd_addr_q;

  // Stored tag in the low bits, dirty flag just above it.
  function automatic logic [31:0] tag_word(input logic [set_bits-1:0] set, input way_t way);
    logic [31:0] word;
    word = ({set, way} * 32'h0001_9e37 + 32'h0000_0a51) & ((32'h1 << tag_bits) - 1);
    word[tag_bits] = way[0] ^ set[0];
    return word;
  endfunction

  function automatic logic [31:0] data_word(input way_t way, input logic [set_bits-1:0] set,
                                            input logic [word_bits-1:0] word);
    return 32'hd500_0000 ^ (32'(way) << 24) ^ (32'(set) << 8) ^ (32'(word) * 32'h0001_0011);
  endfunction

  initial begin
    tag_read_data      = '0;
    data_read_data     = '0;
    av_read_data       = '0;
    av_read_data_valid = 1'b0;
    rd_valid_q         = 1'b0;
  end

  always @(posedge clk) begin
    tag_read_data  <= tag_word(tag_read_address, tag_channel);
    data_read_data <= data_word(data_channel, data_read_address[set_bits+word_bits-1:word_bits],
                                data_read_address[word_bits-1:0]);
    // Read data returns two cycles after acceptance.
    rd_valid_q         <= av_cmd.read && !av_wait_request;
    rd_addr_q          <= av_cmd.address;
    av_read_data_valid <= rd_valid_q;
    av_read_data       <= rd_valid_q ? ~rd_addr_q : 32'h0;
  end

endmodule

`default_nettype wire

/* tests/cache_ri_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri_tb;

  import cache_ri_pkg::*;

  localparam int set_bits       = 5;
  localparam int fifo_depth     = 2;
  localparam int tag_bits       = 32 - line_offset_bits - set_bits;
  localparam int io_writes      = 6;
  localparam int io_reads       = 6;
  localparam int hit_evicts     = 6;
  localparam int free_evicts    = 6;
  localparam int rr_evicts      = 5;
  localparam int num_requests   = io_writes + io_reads + hit_evicts + free_evicts + rr_evicts + 1;
  localparam int timeout_cycles = 40 * num_requests + 200;
  localparam int evict_hit      = 0;
  localparam int evict_free     = 1;
  localparam int evict_miss     = 2;

  typedef struct packed {
    av_cmd_t cmd;
    logic    beat;
  } exp_cmd_t;

  logic                          clk;
  logic                          rest;
  rw_op_e                        rw_cmd;
  rw_req_t                       rw_req;
  lookup_t                       rw_lookup;
  logic [31:0]                   tag_read_data;
  logic [31:0]                   data_read_data;
  logic                          av_wait_request = 1'b0;
  logic [31:0]                   av_read_data;
  logic                          av_read_data_valid;
  logic                          rw_busy;
  logic                          rw_done;
  logic [31:0]                   rw_rsp_data;
  way_t                          tag_channel;
  way_t                          data_channel;
  logic [set_bits-1:0]           tag_read_address;
  logic [set_bits+word_bits-1:0] data_read_address;
  av_cmd_t                       av_cmd;

  logic [31:0] lfsr = 32'h26f2_22bf;
  logic [31:0] wait_bits;
  way_t        rr_exp [2**set_bits] = '{default: '0};
  exp_cmd_t    exp_q [$];
  exp_cmd_t    exp_item;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;

  cache_ri #(
    .set_bits   (set_bits),
    .fifo_depth (fifo_depth)
  ) i_cache_ri (
    .clk                (clk),
    .rest               (rest),
    .rw_cmd             (rw_cmd),
    .rw_req             (rw_req),
    .rw_lookup          (rw_lookup),
    .tag_read_data      (tag_read_data),
    .data_read_data     (data_read_data),
    .av_wait_request    (av_wait_request),
    .av_read_data       (av_read_data),
    .av_read_data_valid (av_read_data_valid),
    .rw_busy            (rw_busy),
    .rw_done            (rw_done),
    .rw_rsp_data        (rw_rsp_data),
    .tag_channel        (tag_channel),
    .tag_read_address   (tag_read_address),
    .data_channel       (data_channel),
    .data_read_address  (data_read_address),
    .av_cmd             (av_cmd)
  );

  cache_ri_tb_mem #(
    .set_bits (set_bits)
  ) i_mem (
    .clk                (clk),
    .tag_channel        (tag_channel),
    .tag_read_address   (tag_read_address),
    .data_channel       (data_channel),
    .data_read_address  (data_read_address),
    .av_cmd             (av_cmd),
    .av_wait_request    (av_wait_request),
    .tag_read_data      (tag_read_data),
    .data_read_data     (data_read_data),
    .av_read_data       (av_read_data),
    .av_read_data_valid (av_read_data_valid)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random source and reference functions.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic way_t expected_way(input lookup_t lkp, input way_t counter);
    if (lkp.hit) begin
      return lkp.hit_way;
    end
    if (lkp.has_free) begin
      return lkp.free_way;
    end
    return counter;
  endfunction

  function automatic logic [31:0] line_address(input logic [tag_bits-1:0] tag,
                                               input logic [set_bits-1:0] set);
    return {tag, set, {line_offset_bits{1'b0}}};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    check_count++;
    assert (got === want) else begin
      error_count++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic compare_cmd(input av_cmd_t got, input exp_cmd_t want);
    check_value("av_cmd.address", got.address, want.cmd.address);
    check_value("av_cmd.read", got.read, want.cmd.read);
    check_value("av_cmd.write", got.write, want.cmd.write);
    check_value("av_cmd.byte_enable", got.byte_enable, want.cmd.byte_enable);
    if (want.cmd.write) begin
      check_value("av_cmd.write_data", got.write_data, want.cmd.write_data);
    end
    if (want.beat) begin
      check_value("av_cmd.begin_burst", got.begin_burst, want.cmd.begin_burst);
      check_value("av_cmd.burst_count", got.burst_count, want.cmd.burst_count);
    end
  endtask

  task automatic check_idle();
    check_value("rw_done", rw_done, 1'b0);
    check_value("rw_busy", rw_busy, 1'b0);
    check_value("av_cmd.read", av_cmd.read, 1'b0);
    check_value("av_cmd.write", av_cmd.write, 1'b0);
  endtask

  // Every accepted bus command must match the head of the queue.
  always @(negedge clk) begin
    if (rest && (av_cmd.read || av_cmd.write) && !av_wait_request) begin
      check_count++;
      assert (exp_q.size() != 0) else begin
        error_count++;
        $display("Avalon command to %h accepted at %0t with none expected", av_cmd.address, $time);
      end
      if (exp_q.size() != 0) begin
        exp_item = exp_q.pop_front();
        compare_cmd(av_cmd, exp_item);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock, wait states and timeout.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Slave stalls about one cycle in four.
  always @(posedge clk) begin
    take_bits(2, wait_bits);
    av_wait_request <= (wait_bits[1:0] == 2'b00);
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Run stopped after %0d cycles with a request still unfinished", cycle_count);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("Simulation failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_request(input rw_op_e op, input rw_req_t req, input lookup_t lkp,
                             output int latency);
    @(posedge clk);
    rw_cmd    <= op;
    rw_req    <= req;
    rw_lookup <= lkp;
    latency = 0;
    @(negedge clk);
    while (!rw_done) begin
      @(posedge clk);
      rw_cmd <= rw_nop;
      @(negedge clk);
      check_value("rw_busy", rw_busy, 1'b1);
      latency++;
    end
  endtask

  task automatic close_request();
    @(posedge clk);
    check_count++;
    assert (exp_q.size() == 0) else begin
      error_count++;
      $display("%0d expected Avalon commands never accepted by %0t", exp_q.size(), $time);
    end
    exp_q.delete();
  endtask

  task automatic run_io(input logic is_read);
    rw_req_t     req;
    exp_cmd_t    item;
    logic [31:0] bits;
    int          latency;
    @(negedge clk);
    req = '0;
    take_bits(32, bits);
    req.address = bits;
    take_bits(4, bits);
    req.byte_enable = bits[3:0];
    take_bits(32, bits);
    req.write_data = bits;
    req.read       = is_read;
    req.write      = !is_read;
    item = '0;
    item.cmd.address     = req.address;
    item.cmd.byte_enable = req.byte_enable;
    item.cmd.read        = req.read;
    item.cmd.write       = req.write;
    item.cmd.write_data  = req.write_data;
    exp_q.push_back(item);
    run_request(rw_io, req, '0, latency);
    if (is_read) begin
      check_value("rw_rsp_data", rw_rsp_data, ~req.address);
    end
    close_request();
  endtask

  task automatic run_evict(input int kind, input logic [set_bits-1:0] fixed_set);
    rw_req_t             req;
    lookup_t             lkp;
    exp_cmd_t            item;
    logic [31:0]         bits;
    logic [31:0]         tword;
    logic [set_bits-1:0] set;
    way_t                way;
    int                  latency;
    @(negedge clk);
    take_bits(set_bits, bits);
    set = (kind == evict_miss) ? fixed_set : bits[set_bits-1:0];
    take_bits(4, bits);
    lkp.hit      = (kind == evict_hit);
    lkp.hit_way  = bits[1:0];
    lkp.has_free = (kind == evict_free) || ((kind == evict_hit) && bits[2]);
    lkp.free_way = bits[3:2];
    take_bits(32, bits);
    req = '0;
    req.address = bits;
    req.address[line_offset_bits +: set_bits] = set;
    way = expected_way(lkp, rr_exp[set]);
    if (!lkp.hit && !lkp.has_free) begin
      rr_exp[set] = way_t'(rr_exp[set] + 1'b1);
    end
    tword = i_mem.tag_word(set, way);
    if (tword[tag_bits]) begin
      for (int k = 0; k < line_words; k++) begin
        item = '0;
        item.beat                 = 1'b1;
        item.cmd.address          = line_address(tword[tag_bits-1:0], set) + 32'(4 * k);
        item.cmd.byte_enable      = 4'hf;
        item.cmd.write            = 1'b1;
        item.cmd.write_data       = i_mem.data_word(way, set, word_bits'(k));
        item.cmd.begin_burst      = (k == 0);
        item.cmd.burst_count      = burst_count_bits'(line_words);
        exp_q.push_back(item);
      end
    end
    run_request(rw_evict, req, lkp, latency);
    check_value("tag_channel", tag_channel, way);
    check_value("data_channel", data_channel, way);
    if (!tword[tag_bits]) begin
      check_value("clean evict latency", latency, 3);
    end
    close_request();
  endtask

  initial begin
    rest      = 1'b0;
    rw_cmd    = rw_nop;
    rw_req    = '0;
    rw_lookup = '0;
    repeat (5) @(posedge clk);
    rest <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_idle();
    end
    for (int i = 0; i < io_writes; i++) begin
      run_io(1'b0);
    end
    for (int i = 0; i < io_reads; i++) begin
      run_io(1'b1);
    end
    for (int i = 0; i < hit_evicts; i++) begin
      run_evict(evict_hit, '0);
    end
    for (int i = 0; i < free_evicts; i++) begin
      run_evict(evict_free, '0);
    end
    // Round-robin walk on one set, then a fresh set.
    for (int i = 0; i < rr_evicts; i++) begin
      run_evict(evict_miss, set_bits'(9));
    end
    run_evict(evict_miss, set_bits'(10));
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cache_ri.f */
hw/cache_ri_pkg.sv
hw/cache_ri_cmd_fifo.sv
hw/cache_ri_way_select.sv
hw/cache_ri_writeback.sv
hw/cache_ri_ctrl.sv
hw/cache_ri.sv
tests/cache_ri_tb_mem.sv
tests/cache_ri_tb.sv

/* Bender.yml */
package:
  name: cache_ri

sources:
  - hw/cache_ri_pkg.sv
  - hw/cache_ri_cmd_fifo.sv
  - hw/cache_ri_way_select.sv
  - hw/cache_ri_writeback.sv
  - hw/cache_ri_ctrl.sv
  - hw/cache_ri.sv
  - target: test
    files:
      - tests/cache_ri_tb_mem.sv
      - tests/cache_ri_tb.sv
